// File: hdl/chipbus_pkg.sv
// chip bus widths, word types and the cpu address map
// custom register offsets and interrupt bit positions
// decode and fsm enums, byte enable merge helper

package chipbus_pkg;

	// ----------------------------------------
	// widths and word types
	localparam int ADDR_W     = 24;           // cpu byte address
	localparam int DATA_W     = 16;
	localparam int RAM_AW     = 10;           // chip ram word address
	localparam int CHIP_WORDS = 1 << RAM_AW;  // 1024 words

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [1:0]        be_t;          // bit 1 is the upper byte
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// ----------------------------------------
	// address map, byte ranges inclusive
	localparam addr_t CHIP_BASE = 24'h000000;
	localparam addr_t CHIP_TOP  = 24'h0007FF;
	localparam addr_t REG_BASE  = 24'hDFF000;
	localparam addr_t REG_TOP   = 24'hDFF0FF;

	// custom register byte offsets
	localparam logic [7:0] REG_DMAPTR = 8'h00; // word pointer
	localparam logic [7:0] REG_DMALEN = 8'h02; // word count
	localparam logic [7:0] REG_DMACON = 8'h04; // bit 0 start / busy
	localparam logic [7:0] REG_INTENA = 8'h06;
	localparam logic [7:0] REG_INTREQ = 8'h08;

	// interrupt bits
	localparam int INT_SETCLR = 15; // 1 sets, 0 clears the named bits
	localparam int INT_MASTER = 14;
	localparam int INT_PORTS  = 3;  // level 2
	localparam int INT_BLIT   = 6;  // level 3

	// cpu slowdown, cycles of waiting before the cpu beats dma
	localparam int BLS_LIMIT = 3;
	localparam int BLS_W     = $clog2(BLS_LIMIT + 1);

	// ----------------------------------------
	typedef enum logic [1:0] {REGION_CHIP, REGION_REG, REGION_NONE} region_e;
	typedef enum logic [1:0] {BR_IDLE, BR_REQ, BR_WAIT, BR_RESP} bridge_state_e;
	typedef enum logic {FE_IDLE, FE_RUN} fetch_state_e;

	// replace only the enabled bytes of a word
	function automatic data_t be_merge(data_t old_d, data_t new_d, be_t be);
		data_t m;
		m = old_d;
		if (be[1])
			m[15:8] = new_d[15:8];
		if (be[0])
			m[7:0] = new_d[7:0];
		return m;
	endfunction

endpackage

// File: hdl/chip_ram.sv
// single port chip ram, 1024 words of 16 bits
// byte enable writes, read data registered one cycle after the address

`timescale 1ns/100ps

module chip_ram (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ram_we_i,
	input  chipbus_pkg::be_t       ram_be_i,
	input  chipbus_pkg::ram_addr_t ram_addr_i,
	input  chipbus_pkg::data_t     ram_wdata_i,
	output chipbus_pkg::data_t     ram_rdata_o
);

	import chipbus_pkg::*;

	data_t mem [0:CHIP_WORDS-1]; // chip memory array

	// write port, untouched bytes keep their old value
	always_ff @(posedge clk) begin
		if (ram_we_i)
			mem[ram_addr_i] <= be_merge(mem[ram_addr_i], ram_wdata_i, ram_be_i);
	end

	// read every cycle, requesters know when the word is theirs
	always_ff @(posedge clk) begin
		if (reset)
			ram_rdata_o <= '0;
		else
			ram_rdata_o <= mem[ram_addr_i]; // old data on a write cycle
	end

endmodule

// File: hdl/chip_arbiter.sv
// chip ram arbiter between cpu bridge and dma fetch
// dma has priority, cpu wins once it has waited BLS_LIMIT cycles
// muxes the winner onto the ram port

`timescale 1ns/100ps

module chip_arbiter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_req_i,
	input  chipbus_pkg::addr_t     cpu_addr_i,
	input  logic                   cpu_we_i,
	input  chipbus_pkg::be_t       cpu_be_i,
	input  chipbus_pkg::data_t     cpu_wdata_i,
	input  logic                   dma_req_i,
	input  chipbus_pkg::ram_addr_t dma_addr_i,
	output logic                   cpu_gnt_o,
	output logic                   dma_gnt_o,
	output logic                   ram_we_o,
	output chipbus_pkg::be_t       ram_be_o,
	output chipbus_pkg::ram_addr_t ram_addr_o,
	output chipbus_pkg::data_t     ram_wdata_o
);

	import chipbus_pkg::*;

	logic [BLS_W-1:0] wait_cnt; // cycles the cpu has been held off
	logic             cpu_first;

	// ----------------------------------------
	// slot decision
	assign cpu_first = cpu_req_i && (!dma_req_i || wait_cnt >= BLS_W'(BLS_LIMIT));
	assign cpu_gnt_o = cpu_first;
	assign dma_gnt_o = dma_req_i && !cpu_first; // never both

	always_ff @(posedge clk) begin
		if (reset)
			wait_cnt <= '0;
		else if (cpu_gnt_o)
			wait_cnt <= '0;
		else if (cpu_req_i && wait_cnt < BLS_W'(BLS_LIMIT))
			wait_cnt <= wait_cnt + 1'b1; // saturates at the limit
	end

	// ----------------------------------------
	// ram port from the winner, dma only reads
	assign ram_we_o    = cpu_gnt_o && cpu_we_i;
	assign ram_be_o    = cpu_gnt_o ? cpu_be_i : 2'b11;
	assign ram_addr_o  = cpu_gnt_o ? cpu_addr_i[RAM_AW:1] : dma_addr_i; // byte to word
	assign ram_wdata_o = cpu_wdata_i;

endmodule

// File: hdl/custom_regs.sv
// custom registers: dma pointer, length and control
// intena / intreq with set/clear writes
// cpu interrupt priority encoder, active low

`timescale 1ns/100ps

module custom_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   reg_we_i,
	input  logic [7:0]             reg_addr_i,
	input  chipbus_pkg::data_t     reg_wdata_i,
	input  chipbus_pkg::be_t       reg_be_i,
	input  logic                   dma_busy_i,
	input  logic                   dma_done_i,
	input  logic                   ext_int2_i,
	output chipbus_pkg::data_t     reg_rdata_o,
	output chipbus_pkg::ram_addr_t dma_ptr_o,
	output chipbus_pkg::data_t     dma_len_o,
	output logic                   dma_start_o,
	output logic [2:0]             ipl_n_o
);

	import chipbus_pkg::*;

	data_t      intena_q, intreq_q;
	data_t      intena_d, intreq_d;
	data_t      wmask;   // enabled data bits, set/clr bit masked off
	data_t      pending;
	logic [2:0] level;

	function automatic data_t set_clr(data_t cur, data_t mask, logic set);
		if (set)
			return cur | mask;
		return cur & ~mask;
	endfunction

	assign wmask = {{8{reg_be_i[1]}}, {8{reg_be_i[0]}}} & reg_wdata_i
		& ~(data_t'(1) << INT_SETCLR);

	// ----------------------------------------
	// interrupt registers
	always_comb begin
		intena_d = intena_q;
		intreq_d = intreq_q;
		if (reg_we_i && reg_addr_i == REG_INTENA)
			intena_d = set_clr(intena_q, wmask, reg_wdata_i[INT_SETCLR]);
		if (reg_we_i && reg_addr_i == REG_INTREQ)
			intreq_d = set_clr(intreq_q, wmask, reg_wdata_i[INT_SETCLR]);
		if (dma_done_i)
			intreq_d[INT_BLIT] = 1'b1;  // block fetch finished
		if (ext_int2_i)
			intreq_d[INT_PORTS] = 1'b1; // level input, re-sets while high
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dma_ptr_o   <= '0;
			dma_len_o   <= '0;
			intena_q    <= '0;
			intreq_q    <= '0;
			dma_start_o <= 1'b0;
		end else begin
			intena_q    <= intena_d;
			intreq_q    <= intreq_d;
			dma_start_o <= reg_we_i && reg_addr_i == REG_DMACON && reg_be_i[0] && reg_wdata_i[0];
			if (reg_we_i && reg_addr_i == REG_DMAPTR)
				dma_ptr_o <= RAM_AW'(be_merge(data_t'(dma_ptr_o), reg_wdata_i, reg_be_i));
			if (reg_we_i && reg_addr_i == REG_DMALEN)
				dma_len_o <= be_merge(dma_len_o, reg_wdata_i, reg_be_i);
		end
	end

	// read mux
	always_comb begin
		case (reg_addr_i)
			REG_DMAPTR: reg_rdata_o = data_t'(dma_ptr_o);
			REG_DMALEN: reg_rdata_o = dma_len_o;
			REG_DMACON: reg_rdata_o = data_t'(dma_busy_i);
			REG_INTENA: reg_rdata_o = intena_q;
			REG_INTREQ: reg_rdata_o = intreq_q;
			default:    reg_rdata_o = '0; // hole in the register page
		endcase
	end

	// ----------------------------------------
	// priority encode, blitter above ports
	always_comb begin
		pending = intena_q & intreq_q;
		level   = 3'd0;
		if (intena_q[INT_MASTER]) begin
			if (pending[INT_BLIT])
				level = 3'd3;
			else if (pending[INT_PORTS])
				level = 3'd2;
		end
	end

	assign ipl_n_o = ~level;

endmodule

// File: hdl/cpu_bridge.sv
// cpu bridge: address decode into chip ram, registers or nothing
// chip ram bus request and read capture, register access
// valid/ready response to the cpu master

`timescale 1ns/100ps

module cpu_bridge (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_valid_i,
	input  chipbus_pkg::addr_t cpu_addr_i,
	input  logic               cpu_we_i,
	input  chipbus_pkg::be_t   cpu_be_i,
	input  chipbus_pkg::data_t cpu_wdata_i,
	input  logic               cpu_gnt_i,
	input  chipbus_pkg::data_t ram_rdata_i,
	input  chipbus_pkg::data_t reg_rdata_i,
	output logic               cpu_ready_o,
	output chipbus_pkg::data_t cpu_rdata_o,
	output logic               cpu_req_o,
	output chipbus_pkg::addr_t cpu_bus_addr_o,
	output logic               cpu_bus_we_o,
	output chipbus_pkg::be_t   cpu_bus_be_o,
	output chipbus_pkg::data_t cpu_bus_wdata_o,
	output logic               reg_we_o,
	output logic [7:0]         reg_addr_o,
	output chipbus_pkg::data_t reg_wdata_o,
	output chipbus_pkg::be_t   reg_be_o
);

	import chipbus_pkg::*;

	bridge_state_e state;
	region_e       region;   // live decode
	region_e       region_q; // taken in idle
	data_t         rdata_q;

	// ----------------------------------------
	// decode, wrap-around subtract gives the range test
	always_comb begin
		if ((cpu_addr_i - CHIP_BASE) <= (CHIP_TOP - CHIP_BASE))
			region = REGION_CHIP;
		else if ((cpu_addr_i - REG_BASE) <= (REG_TOP - REG_BASE))
			region = REGION_REG;
		else
			region = REGION_NONE;
	end

	// ----------------------------------------
	// access sequence
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= BR_IDLE;
		end else begin
			case (state)
				BR_IDLE: if (cpu_valid_i) state <= BR_REQ;
				BR_REQ: begin
					if (region_q != REGION_CHIP)
						state <= BR_RESP;                      // reg or unmapped
					else if (cpu_gnt_i)
						state <= cpu_we_i ? BR_RESP : BR_WAIT; // read waits for ram
				end
				BR_WAIT: state <= BR_RESP;
				BR_RESP: state <= BR_IDLE;
				default: state <= BR_IDLE;
			endcase
		end
	end

	// response data, zero unless a read returns something
	always_ff @(posedge clk) begin
		if (state == BR_IDLE)
			region_q <= region;
		if (state == BR_REQ) begin
			if (region_q == REGION_REG && !cpu_we_i)
				rdata_q <= reg_rdata_i;
			else
				rdata_q <= '0;
		end
		if (state == BR_WAIT)
			rdata_q <= ram_rdata_i; // ram output, one cycle after grant
	end

	assign cpu_ready_o = state == BR_RESP;
	assign cpu_rdata_o = rdata_q;

	// chip bus side, master holds the request stable
	assign cpu_req_o       = state == BR_REQ && region_q == REGION_CHIP;
	assign cpu_bus_addr_o  = cpu_addr_i;
	assign cpu_bus_we_o    = cpu_we_i;
	assign cpu_bus_be_o    = cpu_be_i;
	assign cpu_bus_wdata_o = cpu_wdata_i;

	// register side
	assign reg_we_o    = state == BR_REQ && region_q == REGION_REG && cpu_we_i;
	assign reg_addr_o  = cpu_addr_i[7:0]; // byte offset in the page
	assign reg_wdata_o = cpu_wdata_i;
	assign reg_be_o    = cpu_be_i;

endmodule

// File: hdl/dma_fetch.sv
// dma fetch sequencer, reads a block of chip ram words
// credit limited requests, several reads in flight
// two entry fifo drives the valid/ready output stream

`timescale 1ns/100ps

module dma_fetch (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dma_start_i,
	input  chipbus_pkg::ram_addr_t dma_ptr_i,
	input  chipbus_pkg::data_t     dma_len_i,
	input  logic                   dma_gnt_i,
	input  chipbus_pkg::data_t     ram_rdata_i,
	input  logic                   dma_ready_i,
	output logic                   dma_req_o,
	output chipbus_pkg::ram_addr_t dma_addr_o,
	output logic                   dma_busy_o,
	output logic                   dma_done_o,
	output logic                   dma_valid_o,
	output chipbus_pkg::data_t     dma_data_o
);

	import chipbus_pkg::*;

	fetch_state_e state;
	data_t        req_left;   // words still to request
	data_t        out_left;   // words still to leave the stream
	logic         rd_pend;    // read granted last cycle
	data_t        fifo_mem [0:1];
	logic         wr_ptr, rd_ptr;
	logic [1:0]   fifo_cnt;
	logic         push, pop;

	assign push        = rd_pend; // ram word arrives now
	assign pop         = dma_valid_o && dma_ready_i;
	assign dma_valid_o = fifo_cnt != 2'd0;
	assign dma_data_o  = fifo_mem[rd_ptr];
	assign dma_busy_o  = state == FE_RUN;

	// one request per free slot, counting the read in flight
	// a word leaving the stream this cycle frees its slot
	assign dma_req_o = state == FE_RUN && req_left != '0
		&& (fifo_cnt + {1'b0, rd_pend}) < (2'd2 + {1'b0, pop});

	// ----------------------------------------
	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= FE_IDLE;
			rd_pend    <= 1'b0;
			dma_done_o <= 1'b0;
		end else begin
			rd_pend    <= dma_gnt_i;
			dma_done_o <= 1'b0;
			case (state)
				FE_IDLE: if (dma_start_i) begin
					if (dma_len_i == '0)
						dma_done_o <= 1'b1; // empty block, done at once
					else
						state <= FE_RUN;
				end
				FE_RUN: if (pop && out_left == 16'd1) begin
					state      <= FE_IDLE; // last word gone
					dma_done_o <= 1'b1;
				end
				default: state <= FE_IDLE;
			endcase
		end
	end

	// address and counts, loaded at start (busy starts are ignored)
	always_ff @(posedge clk) begin
		if (state == FE_IDLE && dma_start_i) begin
			dma_addr_o <= dma_ptr_i;
			req_left   <= dma_len_i;
			out_left   <= dma_len_i;
		end else begin
			if (dma_gnt_i) begin
				dma_addr_o <= dma_addr_o + 1'b1;
				req_left   <= req_left - 1'b1;
			end
			if (pop)
				out_left <= out_left - 1'b1;
		end
	end

	// ----------------------------------------
	// output fifo
	always_ff @(posedge clk) begin
		if (push)
			fifo_mem[wr_ptr] <= ram_rdata_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= 1'b0;
			rd_ptr   <= 1'b0;
			fifo_cnt <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			case ({push, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 2'd1;
				2'b01:   fifo_cnt <= fifo_cnt - 2'd1;
				default: fifo_cnt <= fifo_cnt; // none or both
			endcase
		end
	end

endmodule

// File: hdl/chipbus_top.sv
// chip bus core top level
// cpu bridge and dma fetch share chip ram through the arbiter
// custom registers hold dma setup and interrupt state

`timescale 1ns/100ps

module chipbus_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_valid_i,
	input  chipbus_pkg::addr_t cpu_addr_i,
	input  logic               cpu_we_i,
	input  chipbus_pkg::be_t   cpu_be_i,
	input  chipbus_pkg::data_t cpu_wdata_i,
	input  logic               dma_ready_i,
	input  logic               ext_int2_i,
	output logic               cpu_ready_o,
	output chipbus_pkg::data_t cpu_rdata_o,
	output logic               dma_valid_o,
	output chipbus_pkg::data_t dma_data_o,
	output logic [2:0]         ipl_n_o
);

	import chipbus_pkg::*;

	// ----------------------------------------
	// chip bus requests and ram port
	logic      cpu_req, cpu_gnt, cpu_bus_we;
	addr_t     cpu_bus_addr;
	be_t       cpu_bus_be;
	data_t     cpu_bus_wdata;
	logic      dma_req, dma_gnt;
	ram_addr_t dma_bus_addr;
	logic      ram_we;
	be_t       ram_be;
	ram_addr_t ram_addr;
	data_t     ram_wdata, ram_rdata; // rdata goes to both requesters

	// register bus and dma control
	logic       reg_we;
	logic [7:0] reg_addr;
	data_t      reg_wdata, reg_rdata;
	be_t        reg_be;
	ram_addr_t  dma_ptr;
	data_t      dma_len;
	logic       dma_start, dma_busy, dma_done;

	cpu_bridge u_bridge (
		.clk(clk), .reset(reset),
		.cpu_valid_i(cpu_valid_i), .cpu_addr_i(cpu_addr_i), .cpu_we_i(cpu_we_i),
		.cpu_be_i(cpu_be_i), .cpu_wdata_i(cpu_wdata_i),
		.cpu_gnt_i(cpu_gnt), .ram_rdata_i(ram_rdata), .reg_rdata_i(reg_rdata),
		.cpu_ready_o(cpu_ready_o), .cpu_rdata_o(cpu_rdata_o), .cpu_req_o(cpu_req),
		.cpu_bus_addr_o(cpu_bus_addr), .cpu_bus_we_o(cpu_bus_we),
		.cpu_bus_be_o(cpu_bus_be), .cpu_bus_wdata_o(cpu_bus_wdata),
		.reg_we_o(reg_we), .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata), .reg_be_o(reg_be)
	);

	dma_fetch u_fetch (
		.clk(clk), .reset(reset),
		.dma_start_i(dma_start), .dma_ptr_i(dma_ptr), .dma_len_i(dma_len),
		.dma_gnt_i(dma_gnt), .ram_rdata_i(ram_rdata), .dma_ready_i(dma_ready_i),
		.dma_req_o(dma_req), .dma_addr_o(dma_bus_addr), .dma_busy_o(dma_busy),
		.dma_done_o(dma_done), .dma_valid_o(dma_valid_o), .dma_data_o(dma_data_o)
	);

	chip_arbiter u_arb (
		.clk(clk), .reset(reset),
		.cpu_req_i(cpu_req), .cpu_addr_i(cpu_bus_addr), .cpu_we_i(cpu_bus_we),
		.cpu_be_i(cpu_bus_be), .cpu_wdata_i(cpu_bus_wdata),
		.dma_req_i(dma_req), .dma_addr_i(dma_bus_addr),
		.cpu_gnt_o(cpu_gnt), .dma_gnt_o(dma_gnt), .ram_we_o(ram_we),
		.ram_be_o(ram_be), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata)
	);

	chip_ram u_ram (
		.clk(clk), .reset(reset),
		.ram_we_i(ram_we), .ram_be_i(ram_be), .ram_addr_i(ram_addr),
		.ram_wdata_i(ram_wdata), .ram_rdata_o(ram_rdata)
	);

	custom_regs u_regs (
		.clk(clk), .reset(reset),
		.reg_we_i(reg_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_be_i(reg_be),
		.dma_busy_i(dma_busy), .dma_done_i(dma_done), .ext_int2_i(ext_int2_i),
		.reg_rdata_o(reg_rdata), .dma_ptr_o(dma_ptr), .dma_len_o(dma_len),
		.dma_start_o(dma_start), .ipl_n_o(ipl_n_o)
	);

endmodule

// File: test/tb_clock.sv
// testbench clock and reset generator
// 20 ns clock, reset held high for the first 5 cycles

`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam realtime HALF_PERIOD = 10ns;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: test/chipbus_asserts.sv
// concurrent checks on the chip bus top level
// grant exclusion, cpu ready pulse, dma stream hold, ipl after reset
// bound into chipbus_top below

`timescale 1ns/100ps

module chipbus_asserts (
	input logic                   clk,
	input logic                   reset,
	input logic                   cpu_gnt_i,
	input logic                   dma_gnt_i,
	input logic                   cpu_valid_i,
	input logic                   cpu_ready_i,
	input logic                   dma_valid_i,
	input logic                   dma_ready_i,
	input chipbus_pkg::data_t     dma_data_i,
	input logic [2:0]             ipl_n_i
);

	// ----------------------------------------
	// arbiter and cpu port
	grant_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(cpu_gnt_i && dma_gnt_i))
		else $error("cpu and dma granted in the same cycle");

	ready_pulse: assert property (@(posedge clk) disable iff (reset)
		cpu_ready_i |=> !cpu_ready_i)
		else $error("cpu ready held longer than one cycle");

	ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
		cpu_ready_i |-> cpu_valid_i)
		else $error("cpu ready without a valid request");

	// ----------------------------------------
	// dma stream holds its word under back-pressure
	stream_hold: assert property (@(posedge clk) disable iff (reset)
		dma_valid_i && !dma_ready_i |=> dma_valid_i && $stable(dma_data_i))
		else $error("dma word dropped or changed while stalled");

	ipl_after_reset: assert property (@(posedge clk)
		reset |=> ipl_n_i == 3'b111)
		else $error("interrupt level not idle after reset");

endmodule

bind chipbus_top chipbus_asserts u_asserts (
	.clk(clk), .reset(reset),
	.cpu_gnt_i(cpu_gnt), .dma_gnt_i(dma_gnt),
	.cpu_valid_i(cpu_valid_i), .cpu_ready_i(cpu_ready_o),
	.dma_valid_i(dma_valid_o), .dma_ready_i(dma_ready_i), .dma_data_i(dma_data_o),
	.ipl_n_i(ipl_n_o)
);

// File: test/tb_chipbus.sv
// directed testbench for the chip bus core
// cpu access task, dma stream collector, interrupt level wait
// five tests, per test report, closing counts and verdict

`timescale 1ns/100ps

module tb_chipbus;

	import chipbus_pkg::*;

	localparam int CPU_TIMEOUT    = 40;  // cycles for one cpu access
	localparam int STREAM_TIMEOUT = 400; // cycles for a whole dma block
	localparam int IRQ_TIMEOUT    = 100;

	logic       clk, reset;
	logic       cpu_valid_i, cpu_we_i, dma_ready_i, ext_int2_i;
	addr_t      cpu_addr_i;
	be_t        cpu_be_i;
	data_t      cpu_wdata_i;
	logic       cpu_ready_o, dma_valid_o;
	data_t      cpu_rdata_o, dma_data_o;
	logic [2:0] ipl_n_o;

	data_t model [0:CHIP_WORDS-1]; // expected chip ram words
	data_t stream_q [$];           // words taken off the dma stream
	int    seed, errors, tests_run, tests_failed;

	tb_clock u_clock (.clk(clk), .reset(reset));

	chipbus_top u_dut (
		.clk(clk), .reset(reset),
		.cpu_valid_i(cpu_valid_i), .cpu_addr_i(cpu_addr_i), .cpu_we_i(cpu_we_i),
		.cpu_be_i(cpu_be_i), .cpu_wdata_i(cpu_wdata_i),
		.dma_ready_i(dma_ready_i), .ext_int2_i(ext_int2_i),
		.cpu_ready_o(cpu_ready_o), .cpu_rdata_o(cpu_rdata_o),
		.dma_valid_o(dma_valid_o), .dma_data_o(dma_data_o), .ipl_n_o(ipl_n_o)
	);

	// ----------------------------------------
	// helpers
	function automatic addr_t chip_byte(int word);
		return CHIP_BASE + addr_t'(2 * word); // word index to byte address
	endfunction

	function automatic addr_t reg_byte(logic [7:0] off);
		return REG_BASE + addr_t'(off);
	endfunction

	// expected word after a write with byte enables
	function automatic data_t put_bytes(data_t old_w, data_t new_w, be_t be);
		data_t keep;
		keep = {{8{!be[1]}}, {8{!be[0]}}};
		return (old_w & keep) | (new_w & ~keep);
	endfunction

	// bit 15 picks set or clear for the other bits
	function automatic data_t set_or_clear(data_t cur, data_t w);
		if (w[15])
			return cur | (w & 16'h7FFF);
		return cur & ~(w & 16'h7FFF);
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH t=%0t %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// one valid/ready access, lat counts cycles from the first valid cycle
	task automatic cpu_access(input addr_t addr, input logic we, input be_t be,
			input data_t wdata, output data_t rdata, output int lat);
		int n;
		n     = 0;
		lat   = -1;
		rdata = '0;
		@(negedge clk);
		cpu_valid_i = 1'b1;
		cpu_addr_i  = addr;
		cpu_we_i    = we;
		cpu_be_i    = be;
		cpu_wdata_i = wdata;
		do begin
			@(negedge clk);
			n++;
		end while (!cpu_ready_o && n < CPU_TIMEOUT);
		if (cpu_ready_o) begin
			rdata = cpu_rdata_o;
			lat   = n;
		end else begin
			$display("ERROR t=%0t cpu access to %h never got ready", $time, addr);
			errors++;
		end
		@(negedge clk); // valid stays up through the ready edge
		cpu_valid_i = 1'b0;
	endtask

	task automatic start_dma(input int ptr, input int len);
		data_t rd;
		int    lat;
		cpu_access(reg_byte(REG_DMAPTR), 1'b1, 2'b11, data_t'(ptr), rd, lat);
		cpu_access(reg_byte(REG_DMALEN), 1'b1, 2'b11, data_t'(len), rd, lat);
		cpu_access(reg_byte(REG_DMACON), 1'b1, 2'b11, 16'h0001, rd, lat);
	endtask

	// random ready, a word counts when valid meets the ready just driven
	task automatic collect_stream(input int len);
		int n;
		int i;
		n = 0;
		stream_q.delete();
		while (stream_q.size() < len && n < STREAM_TIMEOUT) begin
			@(negedge clk);
			n++;
			dma_ready_i = ($random(seed) & 1) != 0;
			if (dma_valid_o && dma_ready_i)
				stream_q.push_back(dma_data_o);
		end
		if (stream_q.size() < len) begin
			$display("ERROR t=%0t dma stream gave %0d of %0d words", $time,
				stream_q.size(), len);
			errors++;
		end
		@(negedge clk);
		dma_ready_i = 1'b1;
		for (i = 0; i < 4; i++) begin
			if (dma_valid_o) begin
				$display("ERROR t=%0t dma stream sent a word past the block", $time);
				errors++;
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_ipl(input logic [2:0] level);
		int n;
		n = 0;
		while (ipl_n_o !== ~level && n < IRQ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (ipl_n_o !== ~level) begin
			$display("ERROR t=%0t ipl_n_o stayed at %0d, level %0d never showed up",
				$time, ipl_n_o, level);
			errors++;
		end
	endtask

	// ----------------------------------------
	// tests
	task automatic test_ram_bytes();
		data_t rd, w;
		int    lat, e0, i;
		e0 = errors;
		if (ipl_n_o !== 3'b111)
			report_mismatch("ipl_n_o", ipl_n_o, 3'b111);
		if (cpu_ready_o !== 1'b0)
			report_mismatch("cpu_ready_o", cpu_ready_o, 1'b0);
		for (i = 0; i < 4; i++) begin
			w = data_t'($random(seed));
			cpu_access(chip_byte(64 + i), 1'b1, 2'b11, w, rd, lat);
			model[64 + i] = w;
		end
		w = data_t'($random(seed));
		cpu_access(chip_byte(65), 1'b1, 2'b10, w, rd, lat); // upper byte only
		model[65] = put_bytes(model[65], w, 2'b10);
		w = data_t'($random(seed));
		cpu_access(chip_byte(66), 1'b1, 2'b01, w, rd, lat); // lower byte only
		model[66] = put_bytes(model[66], w, 2'b01);
		for (i = 0; i < 4; i++) begin
			cpu_access(chip_byte(64 + i), 1'b0, 2'b11, '0, rd, lat);
			if (rd !== model[64 + i])
				report_mismatch("cpu_rdata_o", rd, model[64 + i]);
		end
		end_test("ram byte enables", e0);
	endtask

	task automatic test_reg_unmapped();
		data_t rd;
		int    lat, e0;
		e0 = errors;
		cpu_access(24'h100000, 1'b0, 2'b11, '0, rd, lat); // between both ranges
		if (rd !== 16'h0000)
			report_mismatch("cpu_rdata_o", rd, 16'h0000);
		if (lat != 2)
			report_mismatch("cpu_ready_o latency", lat, 2);
		cpu_access(reg_byte(REG_DMAPTR), 1'b1, 2'b11, 16'h0155, rd, lat);
		cpu_access(reg_byte(REG_DMALEN), 1'b1, 2'b11, 16'h0007, rd, lat);
		cpu_access(reg_byte(REG_DMAPTR), 1'b0, 2'b11, '0, rd, lat);
		if (rd !== 16'h0155)
			report_mismatch("cpu_rdata_o", rd, 16'h0155);
		if (lat != 2)
			report_mismatch("cpu_ready_o latency", lat, 2);
		cpu_access(reg_byte(REG_DMALEN), 1'b0, 2'b11, '0, rd, lat);
		if (rd !== 16'h0007)
			report_mismatch("cpu_rdata_o", rd, 16'h0007);
		end_test("register and unmapped", e0);
	endtask

	task automatic test_dma_stream();
		localparam int BASE = 512;
		localparam int LEN  = 12;
		data_t rd, w;
		int    lat, e0, i;
		e0 = errors;
		for (i = 0; i < LEN; i++) begin
			w = data_t'($random(seed));
			cpu_access(chip_byte(BASE + i), 1'b1, 2'b11, w, rd, lat);
			model[BASE + i] = w;
		end
		start_dma(BASE, LEN);
		fork
			collect_stream(LEN);
			begin
				cpu_access(reg_byte(REG_DMACON), 1'b0, 2'b11, '0, rd, lat);
				if (rd !== 16'h0001)
					report_mismatch("DMACON busy", rd, 16'h0001);
			end
		join
		for (i = 0; i < stream_q.size() && i < LEN; i++) begin
			if (stream_q[i] !== model[BASE + i])
				report_mismatch("dma_data_o", stream_q[i], model[BASE + i]);
		end
		cpu_access(reg_byte(REG_DMACON), 1'b0, 2'b11, '0, rd, lat);
		if (rd !== 16'h0000)
			report_mismatch("DMACON busy", rd, 16'h0000);
		end_test("dma stream", e0);
	endtask

	task automatic test_interrupts();
		data_t rd, ena, req;
		int    lat, e0;
		e0  = errors;
		ena = '0;
		req = '0;
		cpu_access(reg_byte(REG_INTREQ), 1'b1, 2'b11, 16'h7FFF, rd, lat); // clear all
		ena = set_or_clear(ena, 16'hC040); // master and blitter
		cpu_access(reg_byte(REG_INTENA), 1'b1, 2'b11, 16'hC040, rd, lat);
		if (ipl_n_o !== 3'b111)
			report_mismatch("ipl_n_o", ipl_n_o, 3'b111);
		dma_ready_i = 1'b1;
		start_dma(0, 2);
		wait_ipl(3'd3);
		cpu_access(reg_byte(REG_INTREQ), 1'b1, 2'b11, 16'h0040, rd, lat);
		if (ipl_n_o !== 3'b111)
			report_mismatch("ipl_n_o", ipl_n_o, 3'b111);

		// external level 2 source
		ena = set_or_clear(ena, 16'h8008);
		cpu_access(reg_byte(REG_INTENA), 1'b1, 2'b11, 16'h8008, rd, lat);
		@(negedge clk);
		ext_int2_i = 1'b1;
		wait_ipl(3'd2);
		@(negedge clk);
		ext_int2_i = 1'b0;
		cpu_access(reg_byte(REG_INTREQ), 1'b1, 2'b11, 16'h0008, rd, lat);
		if (ipl_n_o !== 3'b111)
			report_mismatch("ipl_n_o", ipl_n_o, 3'b111);

		// clear mode drops only the named bits
		ena = set_or_clear(ena, 16'h0008);
		cpu_access(reg_byte(REG_INTENA), 1'b1, 2'b11, 16'h0008, rd, lat);
		cpu_access(reg_byte(REG_INTENA), 1'b0, 2'b11, '0, rd, lat);
		if (rd !== ena)
			report_mismatch("INTENA", rd, ena);
		req = set_or_clear(req, 16'h8021);
		req = set_or_clear(req, 16'h0001);
		cpu_access(reg_byte(REG_INTREQ), 1'b1, 2'b11, 16'h8021, rd, lat);
		cpu_access(reg_byte(REG_INTREQ), 1'b1, 2'b11, 16'h0001, rd, lat);
		cpu_access(reg_byte(REG_INTREQ), 1'b0, 2'b11, '0, rd, lat);
		if (rd !== req)
			report_mismatch("INTREQ", rd, req);
		end_test("interrupts", e0);
	endtask

	task automatic test_cpu_under_dma();
		data_t rd, w;
		int    lat, e0, n;
		e0 = errors;
		w  = data_t'($random(seed));
		cpu_access(chip_byte(1000), 1'b1, 2'b11, w, rd, lat);
		model[1000] = w;
		dma_ready_i = 1'b1; // stream never stalls, dma asks all the time
		start_dma(0, 64);
		cpu_access(chip_byte(1000), 1'b0, 2'b11, '0, rd, lat);
		if (rd !== model[1000])
			report_mismatch("cpu_rdata_o", rd, model[1000]);
		if (lat > 3 + BLS_LIMIT) begin
			$display("ERROR t=%0t cpu read under dma took %0d cycles", $time, lat);
			errors++;
		end
		n  = 0;
		rd = 16'h0001;
		while (rd[0] && n < 100) begin
			cpu_access(reg_byte(REG_DMACON), 1'b0, 2'b11, '0, rd, lat);
			n++;
		end
		if (rd[0]) begin
			$display("ERROR t=%0t long dma block never finished", $time);
			errors++;
		end
		end_test("cpu progress under dma", e0);
	endtask

	// ----------------------------------------
	initial begin
		int n;
		cpu_valid_i  = 1'b0;
		cpu_addr_i   = '0;
		cpu_we_i     = 1'b0;
		cpu_be_i     = '0;
		cpu_wdata_i  = '0;
		dma_ready_i  = 1'b0;
		ext_int2_i   = 1'b0;
		seed         = 42;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		n            = 0;
		do begin
			@(negedge clk);
			n++;
		end while (reset !== 1'b0 && n < 20);
		if (reset !== 1'b0) begin
			$display("ERROR t=%0t reset never released", $time);
			errors++;
		end
		test_ram_bytes();
		test_reg_unmapped();
		test_dma_stream();
		test_interrupts();
		test_cpu_under_dma();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: chipbus.f
hdl/chipbus_pkg.sv
hdl/chip_ram.sv
hdl/chip_arbiter.sv
hdl/custom_regs.sv
hdl/cpu_bridge.sv
hdl/dma_fetch.sv
hdl/chipbus_top.sv
test/tb_clock.sv
test/chipbus_asserts.sv
test/tb_chipbus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the chip bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_chipbus -f chipbus.f -o sim_chipbus

./obj_dir/sim_chipbus > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
